// File: sources.f
usbPkg.sv
crc16Serial.sv
txSerializer.sv
txLineDriver.sv
rxLineDecoder.sv
rxPacketChecker.sv
usbDataLink.sv
usbDataLinkTb.sv

// File: Bender.yml
package:
  name: usbDataLink

sources:
  - usbPkg.sv
  - crc16Serial.sv
  - txSerializer.sv
  - txLineDriver.sv
  - rxLineDecoder.sv
  - rxPacketChecker.sv
  - usbDataLink.sv
  - target: test
    files:
      - usbDataLinkTb.sv

// File: usbDataLinkTb.sv
`timescale 1ns/1ps
`default_nettype none

module usbDataLinkTb;

  // 20 packets of at most 140 cycles, plus reset
  localparam int timeoutCycles = 20 * 140 + 16;

  logic clock;
  logic reset_n;
  usbPkg::txRequest_t txRequest;
  logic txBusy;
  logic txDone;
  usbPkg::lineOut_t lineOut;
  usbPkg::busState_t lineIn;
  usbPkg::rxResult_t rxResult;

  logic loopback;
  usbPkg::busState_t injLine[$];
  usbPkg::busState_t encLine[$];
  usbPkg::busState_t seenLine[$];
  int encStuffs;
  logic nrziJ;
  int doneCount;
  int busyCount;
  int resultCount;
  int errors;
  int passCount;
  int failCount;
  int cycleCount;

  string expName[$];
  usbPkg::rxStatus_t expStatus[$];
  logic [7:0] expPid[$];
  logic [63:0] expData[$];
  string curName;
  usbPkg::rxStatus_t curStatus;
  logic [7:0] curPid;
  logic [63:0] curData;

  usbDataLink usbDataLink_inst (
    .clock(clock),
    .reset_n(reset_n),
    .txRequest(txRequest),
    .txBusy(txBusy),
    .txDone(txDone),
    .lineOut(lineOut),
    .lineIn(lineIn),
    .rxResult(rxResult)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  ////////////////////
  // reference model
  ////////////////////

  // serial CRC16 over payload bits in wire order
  function automatic logic [15:0] refCrc16(input logic [63:0] data);
    logic [15:0] c;
    logic fb;
    int i;
    c = usbPkg::crcInit;
    for (i = 0; i < 64; i++) begin
      fb = c[15] ^ data[i];
      c = {c[14:0], 1'b0};
      if (fb) begin
        c = c ^ usbPkg::crcPoly;
      end
    end
    return c;
  endfunction

  function automatic void nrziPush(input logic b);
    if (!b) begin
      nrziJ = !nrziJ;
    end
    encLine.push_back(nrziJ ? usbPkg::J : usbPkg::K);
  endfunction

  // fills encLine and encStuffs for one packet
  function automatic void refEncode(input logic [7:0] pidByte, input logic [63:0] data,
                                    input int flipAt, input int dropAt, input logic noStuff);
    logic [15:0] crc;
    logic [63:0] sent;
    logic body[$];
    int ones;
    int i;
    crc = refCrc16(data);
    sent = data;
    if (flipAt >= 0) begin
      sent[flipAt] = ~sent[flipAt];
    end
    for (i = 0; i < 8; i++) begin
      body.push_back(pidByte[i]);
    end
    for (i = 0; i < 64; i++) begin
      if (i != dropAt) begin
        body.push_back(sent[i]);
      end
    end
    for (i = 15; i >= 0; i--) begin
      body.push_back(~crc[i]);
    end
    encLine.delete();
    encStuffs = 0;
    nrziJ = 1'b1;
    ones = 0;
    for (i = 0; i < 8; i++) begin
      nrziPush(usbPkg::syncPattern[i]);
    end
    foreach (body[k]) begin
      nrziPush(body[k]);
      ones = body[k] ? ones + 1 : 0;
      if (ones == usbPkg::maxOnes && !noStuff) begin
        nrziPush(1'b0);
        encStuffs++;
        ones = 0;
      end
    end
    encLine.push_back(usbPkg::SE0);
    encLine.push_back(usbPkg::SE0);
    encLine.push_back(usbPkg::J);
  endfunction

  ////////////////////
  // line source and monitors
  ////////////////////

  always @(negedge clock) begin
    if (loopback) begin
      lineIn = lineOut.oe ? lineOut.state : usbPkg::J;
    end else if (injLine.size() > 0) begin
      lineIn = injLine.pop_front();
    end else begin
      lineIn = usbPkg::J;
    end
  end

  always @(negedge clock) begin
    if (lineOut.oe) begin
      seenLine.push_back(lineOut.state);
    end
    if (txBusy) begin
      busyCount++;
    end
    if (txDone) begin
      doneCount++;
      if (txBusy) begin
        $display("txBusy was still high in the cycle of txDone");
        errors++;
      end
    end
  end

  // compare every result strobe with the next expected entry
  always @(negedge clock) begin
    if (reset_n && rxResult.valid) begin
      if (expName.size() == 0) begin
        $display("receive result came out with no packet expected");
        errors++;
      end else begin
        curName = expName.pop_front();
        curStatus = expStatus.pop_front();
        curPid = expPid.pop_front();
        curData = expData.pop_front();
        if (rxResult.status != curStatus) begin
          $display("ERR %s status expected %0d actual %0d", curName, curStatus,
                   rxResult.status);
          errors++;
        end else if (curStatus == usbPkg::rxOk) begin
          if (rxResult.pid != curPid) begin
            $display("ERR %s pid expected %h actual %h", curName, curPid, rxResult.pid);
            errors++;
          end
          if (rxResult.data != curData) begin
            $display("ERR %s data expected %h actual %h", curName, curData, rxResult.data);
            errors++;
          end
        end
      end
      resultCount++;
    end
  end

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("run timed out after %0d cycles with tests still waiting", cycleCount);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////
  // test tasks
  ////////////////////

  task automatic queueExpected(input string name, input usbPkg::rxStatus_t status,
                               input logic [7:0] pid, input logic [63:0] data);
    expName.push_back(name);
    expStatus.push_back(status);
    expPid.push_back(pid);
    expData.push_back(data);
  endtask

  task automatic finishTest(input string name, input int errBefore);
    if (errors == errBefore) begin
      passCount++;
      $display("test %s passed", name);
    end else begin
      failCount++;
      $display("test %s failed", name);
    end
  endtask

  task automatic runLoopback(input string name, input usbPkg::pid_t pid,
                             input logic [63:0] data);
    int errBefore;
    int waitCount;
    int n;
    logic mismatch;
    errBefore = errors;
    refEncode(pid, data, -1, -1, 1'b0);
    queueExpected(name, usbPkg::rxOk, pid, data);
    seenLine.delete();
    doneCount = 0;
    busyCount = 0;
    waitCount = resultCount;
    @(negedge clock);
    txRequest = '{start: 1'b1, pid: pid, data: data};
    @(negedge clock);
    txRequest.start = 1'b0;
    wait (resultCount != waitCount);
    // let the final J and txDone settle
    repeat (2) @(negedge clock);
    if (doneCount != 1) begin
      $display("ERR %s txDone count expected 1 actual %0d", name, doneCount);
      errors++;
    end
    if (busyCount != 99 + encStuffs) begin
      $display("ERR %s busy cycles expected %0d actual %0d", name, 99 + encStuffs,
               busyCount);
      errors++;
    end
    n = seenLine.size();
    if (n != 99 + encStuffs) begin
      $display("ERR %s oe cycles expected %0d actual %0d", name, 99 + encStuffs, n);
      errors++;
    end else begin
      if (seenLine[n-3] != usbPkg::SE0 || seenLine[n-2] != usbPkg::SE0 ||
          seenLine[n-1] != usbPkg::J) begin
        $display("ERR %s eop expected %b %b %b actual %b %b %b", name, usbPkg::SE0,
                 usbPkg::SE0, usbPkg::J, seenLine[n-3], seenLine[n-2], seenLine[n-1]);
        errors++;
      end
      mismatch = 1'b0;
      foreach (seenLine[k]) begin
        if (!mismatch && seenLine[k] != encLine[k]) begin
          $display("ERR %s line bit %0d expected %b actual %b", name, k, encLine[k],
                   seenLine[k]);
          errors++;
          mismatch = 1'b1;
        end
      end
    end
    finishTest(name, errBefore);
  endtask

  task automatic runInjected(input string name, input logic [7:0] pidByte,
                             input logic [63:0] data, input int flipAt, input int dropAt,
                             input logic noStuff, input usbPkg::rxStatus_t status);
    int errBefore;
    int waitCount;
    errBefore = errors;
    refEncode(pidByte, data, flipAt, dropAt, noStuff);
    queueExpected(name, status, pidByte, data);
    waitCount = resultCount;
    // line source starts popping on the next falling edge
    @(posedge clock);
    injLine = encLine;
    wait (resultCount != waitCount);
    repeat (2) @(negedge clock);
    finishTest(name, errBefore);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    logic [63:0] data;
    usbPkg::pid_t pid;
    void'($urandom(59));
    reset_n = 1'b0;
    txRequest = '0;
    lineIn = usbPkg::J;
    loopback = 1'b1;
    errors = 0;
    passCount = 0;
    failCount = 0;
    cycleCount = 0;
    resultCount = 0;
    doneCount = 0;
    busyCount = 0;
    repeat (16) @(negedge clock);
    reset_n = 1'b1;
    repeat (4) @(negedge clock);

    for (int i = 0; i < 8; i++) begin
      data[63:32] = $urandom();
      data[31:0] = $urandom();
      // long runs of ones to force stuffing
      if (i == 0) begin
        data = '1;
      end else if (i == 1) begin
        data = data | 64'h00FF_F000_0000_0FFF;
      end
      pid = ($urandom() % 2) ? usbPkg::DATA1 : usbPkg::DATA0;
      runLoopback($sformatf("loopback%0d", i), pid, data);
    end

    loopback = 1'b0;
    repeat (4) @(negedge clock);
    data[63:32] = $urandom();
    data[31:0] = $urandom();
    runInjected("flippedBit", usbPkg::DATA1, data, 20, -1, 1'b0, usbPkg::rxBadCrc);
    runInjected("badPid", 8'h43, data, -1, -1, 1'b0, usbPkg::rxBadPid);
    runInjected("droppedBit", usbPkg::DATA0, data, -1, 10, 1'b0, usbPkg::rxBadLength);
    runInjected("noStuffing", usbPkg::DATA0, 64'h0000_0000_0000_00FF, -1, -1, 1'b1,
                usbPkg::rxBadStuff);

    $display("tests passed %0d failed %0d", passCount, failCount);
    if (failCount == 0 && errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: usbDataLink.sv
`timescale 1ns/1ps
`default_nettype none

module usbDataLink (
  input  logic               clock,
  input  logic               reset_n,
  input  usbPkg::txRequest_t txRequest,
  output logic               txBusy,
  output logic               txDone,
  output usbPkg::lineOut_t   lineOut,
  input  usbPkg::busState_t  lineIn,
  output usbPkg::rxResult_t  rxResult
);

  logic rawBit;
  logic rawSe0;
  logic rawActive;
  usbPkg::rxBit_t rxBit;

  ////////////////////
  // transmit path
  ////////////////////

  txSerializer txSerializer_inst (
    .clock(clock),
    .reset_n(reset_n),
    .txRequest(txRequest),
    .txBusy(txBusy),
    .txDone(txDone),
    .rawBit(rawBit),
    .rawSe0(rawSe0),
    .rawActive(rawActive)
  );

  txLineDriver txLineDriver_inst (
    .clock(clock),
    .reset_n(reset_n),
    .rawBit(rawBit),
    .rawSe0(rawSe0),
    .rawActive(rawActive),
    .lineOut(lineOut)
  );

  ////////////////////
  // receive path
  ////////////////////

  rxLineDecoder rxLineDecoder_inst (
    .clock(clock),
    .reset_n(reset_n),
    .lineIn(lineIn),
    .rxBit(rxBit)
  );

  rxPacketChecker rxPacketChecker_inst (
    .clock(clock),
    .reset_n(reset_n),
    .rxBit(rxBit),
    .rxResult(rxResult)
  );

endmodule

`default_nettype wire

// File: rxPacketChecker.sv
`timescale 1ns/1ps
`default_nettype none

module rxPacketChecker (
  input  logic              clock,
  input  logic              reset_n,
  input  usbPkg::rxBit_t    rxBit,
  output usbPkg::rxResult_t rxResult
);

  typedef enum logic [1:0] {
    checkHunt,
    checkPid,
    checkBody,
    checkDrain
  } checkPhase_t;

  checkPhase_t phase;
  usbPkg::rxStatus_t status;
  usbPkg::rxStatus_t finalStatus;
  logic [7:0] shiftReg;
  logic [7:0] shiftNext;
  logic [6:0] bitCnt;
  logic [usbPkg::payloadBits-1:0] dataSh;
  logic [usbPkg::crcBits-1:0] crc;
  logic pidGood;
  logic bodyBit;
  logic resultNow;
  logic resValid;
  usbPkg::rxStatus_t resStatus;
  usbPkg::pid_t resPid;
  logic [usbPkg::payloadBits-1:0] resData;

  // lsb arrives first, so shift in from the top
  assign shiftNext = {rxBit.value, shiftReg[7:1]};
  assign pidGood = (shiftNext[7:4] == ~shiftNext[3:0]) &&
                   (shiftNext == usbPkg::DATA0 || shiftNext == usbPkg::DATA1);
  assign bodyBit = (phase == checkBody) && rxBit.valid;
  assign resultNow = (phase != checkHunt) && rxBit.se0;

  // earlier errors win, then length, then crc
  always_comb begin
    finalStatus = status;
    if (status == usbPkg::rxOk) begin
      if (phase != checkBody ||
          bitCnt != 7'(usbPkg::payloadBits + usbPkg::crcBits)) begin
        finalStatus = usbPkg::rxBadLength;
      end else if (crc != usbPkg::crcResidual) begin
        finalStatus = usbPkg::rxBadCrc;
      end
    end
  end

  ////////////////////
  // packet phases
  ////////////////////

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      phase <= checkHunt;
      status <= usbPkg::rxOk;
      shiftReg <= '1;
      bitCnt <= '0;
      resValid <= 1'b0;
    end else begin
      resValid <= 1'b0;
      if (phase == checkHunt) begin
        if (rxBit.se0) begin
          shiftReg <= '1;
        end else if (rxBit.valid) begin
          shiftReg <= shiftNext;
          if (shiftNext == usbPkg::syncPattern) begin
            phase <= checkPid;
            status <= usbPkg::rxOk;
            bitCnt <= '0;
          end
        end
      end else if (rxBit.se0) begin
        resValid <= 1'b1;
        phase <= checkHunt;
        shiftReg <= '1;
      end else if (rxBit.stuffError) begin
        status <= usbPkg::rxBadStuff;
        phase <= checkDrain;
      end else if (rxBit.valid) begin
        if (phase == checkPid && bitCnt == 7'd7) begin
          bitCnt <= '0;
        end else if (bitCnt != '1) begin
          bitCnt <= bitCnt + 7'd1;
        end
        if (phase == checkPid) begin
          shiftReg <= shiftNext;
          if (bitCnt == 7'd7) begin
            if (pidGood) begin
              phase <= checkBody;
            end else begin
              status <= usbPkg::rxBadPid;
              phase <= checkDrain;
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (bodyBit && bitCnt < 7'(usbPkg::payloadBits)) begin
      dataSh[bitCnt[5:0]] <= rxBit.value;
    end
    if (resultNow) begin
      resStatus <= finalStatus;
      resPid <= usbPkg::pid_t'(shiftReg);
      resData <= dataSh;
    end
  end

  assign rxResult = '{valid: resValid, status: resStatus, pid: resPid, data: resData};

  // held cleared while hunting, runs over payload and crc
  crc16Serial crc16Serial_inst (
    .clock(clock),
    .reset_n(reset_n),
    .clear(phase == checkHunt),
    .enable(bodyBit),
    .dataBit(rxBit.value),
    .crc(crc)
  );

  resultStrobe: assert property (@(posedge clock) disable iff (!reset_n)
    rxResult.valid |=> !rxResult.valid);

endmodule

`default_nettype wire

// File: rxLineDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module rxLineDecoder (
  input  logic              clock,
  input  logic              reset_n,
  input  usbPkg::busState_t lineIn,
  output usbPkg::rxBit_t    rxBit
);

  usbPkg::busState_t prevState;
  logic [2:0] onesCnt;
  logic level;

  // no change on the line decodes as one
  assign level = (lineIn == prevState);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      prevState <= usbPkg::J;
      onesCnt <= '0;
      rxBit <= '0;
    end else begin
      rxBit <= '0;
      case (lineIn)
        usbPkg::J, usbPkg::K: begin
          prevState <= lineIn;
          if (onesCnt == 3'(usbPkg::maxOnes) && !level) begin
            // stuffed zero, dropped
            onesCnt <= '0;
          end else if (onesCnt >= 3'(usbPkg::maxOnes) && level) begin
            // run too long, saturate past the stuff point
            rxBit.stuffError <= 1'b1;
            onesCnt <= 3'(usbPkg::maxOnes + 1);
          end else begin
            rxBit.valid <= 1'b1;
            rxBit.value <= level;
            onesCnt <= level ? onesCnt + 3'd1 : '0;
          end
        end
        usbPkg::SE0: begin
          rxBit.se0 <= 1'b1;
          prevState <= usbPkg::J;
          onesCnt <= '0;
        end
        default: begin
          // SE1 is never legal
          rxBit.stuffError <= 1'b1;
          onesCnt <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: txLineDriver.sv
`timescale 1ns/1ps
`default_nettype none

module txLineDriver (
  input  logic             clock,
  input  logic             reset_n,
  input  logic             rawBit,
  input  logic             rawSe0,
  input  logic             rawActive,
  output usbPkg::lineOut_t lineOut
);

  // nrzi reference, high means J
  logic refJ;
  logic nextJ;
  usbPkg::busState_t nextState;

  // zero toggles, one holds
  assign nextJ = rawBit ? refJ : !refJ;

  always_comb begin
    if (!rawActive) begin
      nextState = usbPkg::J;
    end else if (rawSe0) begin
      nextState = usbPkg::SE0;
    end else if (nextJ) begin
      nextState = usbPkg::J;
    end else begin
      nextState = usbPkg::K;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      refJ <= 1'b1;
      lineOut <= '{state: usbPkg::J, oe: 1'b0};
    end else begin
      // se0 and idle both bring the reference back to J
      refJ <= (nextState != usbPkg::K);
      lineOut <= '{state: nextState, oe: rawActive};
    end
  end

  driveLegal: assert property (@(posedge clock) disable iff (!reset_n)
    lineOut.oe |-> (lineOut.state != usbPkg::SE1));

endmodule

`default_nettype wire

// File: txSerializer.sv
`timescale 1ns/1ps
`default_nettype none

module txSerializer (
  input  logic               clock,
  input  logic               reset_n,
  input  usbPkg::txRequest_t txRequest,
  output logic               txBusy,
  output logic               txDone,
  output logic               rawBit,
  output logic               rawSe0,
  output logic               rawActive
);

  typedef enum logic [2:0] {
    sendIdle,
    sendSync,
    sendPid,
    sendPayload,
    sendCrc,
    sendEop,
    sendIdleJ
  } sendPhase_t;

  sendPhase_t phase;
  logic [5:0] bitCnt;
  logic [2:0] onesCnt;
  logic [7:0] pidQ;
  logic [usbPkg::payloadBits-1:0] dataQ;
  logic [usbPkg::crcBits-1:0] crc;
  logic accept;
  logic stuffNow;
  logic phaseBit;
  logic lastBit;

  assign txBusy = (phase != sendIdle);
  assign accept = txRequest.start && !txBusy;
  assign stuffNow = (onesCnt == 3'(usbPkg::maxOnes));

  // raw outputs come straight from the phase state
  assign rawActive = txBusy;
  assign rawBit = stuffNow ? 1'b0 : phaseBit;
  assign rawSe0 = (phase == sendEop) && !stuffNow;

  ////////////////////
  // bit selection
  ////////////////////

  always_comb begin
    phaseBit = 1'b1;
    lastBit = 1'b0;
    case (phase)
      sendSync: begin
        phaseBit = usbPkg::syncPattern[bitCnt[2:0]];
        lastBit = (bitCnt == 6'd7);
      end
      sendPid: begin
        phaseBit = pidQ[bitCnt[2:0]];
        lastBit = (bitCnt == 6'd7);
      end
      sendPayload: begin
        phaseBit = dataQ[bitCnt];
        lastBit = (bitCnt == 6'(usbPkg::payloadBits - 1));
      end
      sendCrc: begin
        // inverted crc, msb first
        phaseBit = ~crc[4'(usbPkg::crcBits - 1) - bitCnt[3:0]];
        lastBit = (bitCnt == 6'(usbPkg::crcBits - 1));
      end
      sendEop: begin
        phaseBit = 1'b0;
        lastBit = (bitCnt == 6'(usbPkg::eopSe0Bits - 1));
      end
      sendIdleJ: begin
        lastBit = 1'b1;
      end
      default: begin
      end
    endcase
  end

  ////////////////////
  // sequencing
  ////////////////////

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      phase <= sendIdle;
      bitCnt <= '0;
      onesCnt <= '0;
      txDone <= 1'b0;
    end else begin
      txDone <= 1'b0;
      if (phase == sendIdle) begin
        onesCnt <= '0;
        if (accept) begin
          phase <= sendSync;
          bitCnt <= '0;
        end
      end else if (stuffNow) begin
        // stuffed zero goes out, stream holds
        onesCnt <= '0;
      end else begin
        if (phase inside {sendPid, sendPayload, sendCrc} && phaseBit) begin
          onesCnt <= onesCnt + 3'd1;
        end else begin
          onesCnt <= '0;
        end
        bitCnt <= lastBit ? '0 : bitCnt + 6'd1;
        if (lastBit) begin
          case (phase)
            sendSync: phase <= sendPid;
            sendPid: phase <= sendPayload;
            sendPayload: phase <= sendCrc;
            sendCrc: phase <= sendEop;
            sendEop: phase <= sendIdleJ;
            default: begin
              phase <= sendIdle;
              txDone <= 1'b1;
            end
          endcase
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      pidQ <= txRequest.pid;
      dataQ <= txRequest.data;
    end
  end

  // crc covers the payload only, stuffed bits excluded
  crc16Serial crc16Serial_inst (
    .clock(clock),
    .reset_n(reset_n),
    .clear(accept),
    .enable((phase == sendPayload) && !stuffNow),
    .dataBit(phaseBit),
    .crc(crc)
  );

  startWhileBusy: assert property (@(posedge clock) disable iff (!reset_n)
    txRequest.start |-> !txBusy)
    else $error("start request dropped, transmitter busy");

endmodule

`default_nettype wire

// File: crc16Serial.sv
`timescale 1ns/1ps
`default_nettype none

module crc16Serial (
  input  logic                       clock,
  input  logic                       reset_n,
  input  logic                       clear,
  input  logic                       enable,
  input  logic                       dataBit,
  output logic [usbPkg::crcBits-1:0] crc
);

  logic feedback;

  // msb of the register meets the incoming bit
  assign feedback = crc[usbPkg::crcBits-1] ^ dataBit;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      crc <= usbPkg::crcInit;
    end else if (clear) begin
      crc <= usbPkg::crcInit;
    end else if (enable) begin
      // shift left, fold in the polynomial when feedback is set
      if (feedback) begin
        crc <= {crc[usbPkg::crcBits-2:0], 1'b0} ^ usbPkg::crcPoly;
      end else begin
        crc <= {crc[usbPkg::crcBits-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// File: usbPkg.sv
`default_nettype none

package usbPkg;

  ////////////////////
  // link constants
  ////////////////////

  localparam int unsigned payloadBits = 64;
  localparam int unsigned crcBits = 16;
  localparam logic [15:0] crcPoly = 16'h8005;
  localparam logic [15:0] crcInit = 16'hFFFF;
  // remainder left in the receive CRC after data plus inverted CRC
  localparam logic [15:0] crcResidual = 16'h800D;
  // lsb first on the wire, seven zeros then a one
  localparam logic [7:0] syncPattern = 8'h80;
  localparam int unsigned maxOnes = 6;
  localparam int unsigned eopSe0Bits = 2;

  ////////////////////
  // enums and structs
  ////////////////////

  // line state as {dp, dm}
  typedef enum logic [1:0] {
    J = 2'b10,
    K = 2'b01,
    SE0 = 2'b00,
    SE1 = 2'b11
  } busState_t;

  // high nibble is the complement of the low nibble
  typedef enum logic [7:0] {
    DATA0 = 8'hC3,
    DATA1 = 8'h4B
  } pid_t;

  typedef enum logic [2:0] {
    rxOk,
    rxBadStuff,
    rxBadPid,
    rxBadLength,
    rxBadCrc
  } rxStatus_t;

  typedef struct packed {
    logic start;
    pid_t pid;
    logic [payloadBits-1:0] data;
  } txRequest_t;

  typedef struct packed {
    busState_t state;
    logic oe;
  } lineOut_t;

  typedef struct packed {
    logic valid;
    rxStatus_t status;
    pid_t pid;
    logic [payloadBits-1:0] data;
  } rxResult_t;

  // one decoded bit after nrzi and unstuffing
  typedef struct packed {
    logic valid;
    logic value;
    logic se0;
    logic stuffError;
  } rxBit_t;

endpackage

`default_nettype wire
